//--- logic/sdram_cmd_pkg.sv
`default_nettype none

package sdram_cmd_pkg;

  localparam int ADDR_W = 20;  // word address into the part
  localparam int WORD_W = 16;
  localparam int LEN_W  = 5;   // wide enough to hold a 16 word burst

  typedef logic [ADDR_W-1:0] sdram_addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LEN_W-1:0]  burst_len_t;

  // selects which controller request goes high
  typedef enum logic {
    BURST_READ  = 1'b0,
    BURST_WRITE = 1'b1
  } burst_op_e;

  localparam burst_len_t LEN_SINGLE = 5'd1;   // single user write
  localparam burst_len_t LEN_LINE   = 5'd4;   // read cache line fill
  localparam burst_len_t LEN_BLOCK  = 5'd16;  // stream block flush

endpackage

`default_nettype wire

//--- logic/host_port_pkg.sv
`default_nettype none

package host_port_pkg;

  localparam int LINE_WORDS  = 4;
  localparam int BLOCK_WORDS = 16;

  localparam int LINE_OFF_W  = $clog2(LINE_WORDS);
  localparam int BLOCK_IDX_W = $clog2(BLOCK_WORDS);

  // read cache line split
  typedef logic [sdram_cmd_pkg::ADDR_W-LINE_OFF_W-1:0] line_tag_t;
  typedef logic [LINE_OFF_W-1:0]                       line_off_t;

  // stream block split
  typedef logic [sdram_cmd_pkg::ADDR_W-BLOCK_IDX_W-1:0] block_tag_t;
  typedef logic [BLOCK_IDX_W-1:0]                       block_idx_t;

endpackage

`default_nettype wire

//--- logic/burst_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface burst_req_if;

  logic                        req;    // held until ack
  sdram_cmd_pkg::burst_op_e    op;
  sdram_cmd_pkg::sdram_addr_t  addr;
  sdram_cmd_pkg::burst_len_t   len;
  sdram_cmd_pkg::word_t        wdata;  // word for the current beat

  logic                        ack;    // pulsed once the burst finishes
  host_port_pkg::block_idx_t   beat;
  sdram_cmd_pkg::word_t        rdata;
  logic                        rvalid;

  modport requester (
    output req, op, addr, len, wdata,
    input  ack, beat, rdata, rvalid
  );

  modport sequencer (
    input  req, op, addr, len, wdata,
    output ack, beat, rdata, rvalid
  );

endinterface

`default_nettype wire

//--- logic/host_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_port (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_cmd_pkg::sdram_addr_t address,
  input  sdram_cmd_pkg::word_t       data_in,
  input  logic                       read_req,
  input  logic                       write_req,
  input  logic                       write_en,
  output sdram_cmd_pkg::word_t       data_out,
  output logic                       read_ack,
  output logic                       write_ack,
  burst_req_if.requester             line_if
);

  logic read_req_q;
  logic write_req_q;
  logic rd_edge;
  logic wr_edge;
  logic hit;

  host_port_pkg::line_tag_t addr_tag;
  host_port_pkg::line_off_t addr_off;

  logic                     line_valid;
  host_port_pkg::line_tag_t line_tag;
  sdram_cmd_pkg::word_t     line_mem [host_port_pkg::LINE_WORDS];

  host_port_pkg::line_tag_t rd_tag;  // tag of the line being fetched
  host_port_pkg::line_off_t rd_off;

  assign {addr_tag, addr_off} = address;

  assign rd_edge = read_req && !read_req_q;
  assign wr_edge = write_req && !write_req_q;
  assign hit     = line_valid && (line_tag == addr_tag);

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_req_q  <= 1'b0;
      write_req_q <= 1'b0;
    end else begin
      read_req_q  <= read_req;
      write_req_q <= write_req;
    end
  end

  // burst request towards the sequencer
  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      line_if.req <= 1'b0;
      line_if.op  <= sdram_cmd_pkg::BURST_READ;
    end else if (line_if.ack) begin
      line_if.req <= 1'b0;
    end else if (wr_edge) begin
      line_if.req <= 1'b1;
      line_if.op  <= sdram_cmd_pkg::BURST_WRITE;
    end else if (rd_edge && !hit) begin
      line_if.req <= 1'b1;
      line_if.op  <= sdram_cmd_pkg::BURST_READ;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_edge) begin
      line_if.addr  <= address;
      line_if.len   <= sdram_cmd_pkg::LEN_SINGLE;
      line_if.wdata <= data_in;
    end else if (rd_edge && !hit) begin
      line_if.addr <= {addr_tag, 2'b00};  // line aligned
      line_if.len  <= sdram_cmd_pkg::LEN_LINE;
    end
    if (rd_edge) begin
      rd_tag <= addr_tag;
      rd_off <= addr_off;
    end
    if (line_if.rvalid) begin
      line_mem[line_if.beat[host_port_pkg::LINE_OFF_W-1:0]] <= line_if.rdata;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_ack   <= 1'b0;
      write_ack  <= 1'b0;
      data_out   <= '0;
      line_valid <= 1'b0;
      line_tag   <= '0;
    end else begin
      write_ack <= 1'b0;
      if (rd_edge && hit) begin
        read_ack <= 1'b1;
        data_out <= line_mem[addr_off];
      end else if (line_if.ack && line_if.op == sdram_cmd_pkg::BURST_READ) begin
        // line is complete, the last beat landed a cycle ago
        line_valid <= 1'b1;
        line_tag   <= rd_tag;
        read_ack   <= 1'b1;
        data_out   <= line_mem[rd_off];
      end else if (!read_req) begin
        read_ack <= 1'b0;
        data_out <= '0;
      end
      if (line_if.ack && line_if.op == sdram_cmd_pkg::BURST_WRITE) begin
        write_ack <= 1'b1;
      end
      if (wr_edge || write_en) begin
        line_valid <= 1'b0;  // any write may touch the cached line
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/stream_write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_write_buffer (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_cmd_pkg::sdram_addr_t address,
  input  sdram_cmd_pkg::word_t       data_in,
  input  logic                       write_latch_address,
  input  logic                       write_en,
  burst_req_if.requester             block_if
);

  sdram_cmd_pkg::sdram_addr_t stream_addr;
  sdram_cmd_pkg::sdram_addr_t stream_cur;

  host_port_pkg::block_tag_t  cur_tag;
  host_port_pkg::block_idx_t  cur_idx;
  logic                       last_slot;

  // slot 15 goes straight to the back buffer
  sdram_cmd_pkg::word_t       front [host_port_pkg::BLOCK_WORDS-1];
  sdram_cmd_pkg::word_t       back  [host_port_pkg::BLOCK_WORDS];
  host_port_pkg::block_tag_t  back_tag;

  assign stream_cur = write_latch_address ? address : stream_addr;
  assign {cur_tag, cur_idx} = stream_cur;
  assign last_slot = (cur_idx == host_port_pkg::block_idx_t'(host_port_pkg::BLOCK_WORDS - 1));

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stream_addr <= '0;
    end else if (write_en) begin
      stream_addr <= stream_cur + 1'b1;
    end else begin
      stream_addr <= stream_cur;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      if (last_slot) begin
        for (int i = 0; i < host_port_pkg::BLOCK_WORDS - 1; i++) begin
          back[i] <= front[i];
        end
        back[host_port_pkg::BLOCK_WORDS-1] <= data_in;
        back_tag <= cur_tag;
      end else begin
        front[cur_idx] <= data_in;
      end
    end
  end

  // new block wins over a same cycle ack
  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      block_if.req <= 1'b0;
    end else if (write_en && last_slot) begin
      block_if.req <= 1'b1;
    end else if (block_if.ack) begin
      block_if.req <= 1'b0;
    end
  end

  assign block_if.op    = sdram_cmd_pkg::BURST_WRITE;
  assign block_if.len   = sdram_cmd_pkg::LEN_BLOCK;
  assign block_if.addr  = {back_tag, 4'h0};
  assign block_if.wdata = back[block_if.beat];

endmodule

`default_nettype wire

//--- logic/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  burst_req_if.sequencer             line_if,
  burst_req_if.sequencer             block_if,
  output logic                       busy,
  output sdram_cmd_pkg::sdram_addr_t sdram_rw_addr,
  output logic                       sdram_wr_req,
  output sdram_cmd_pkg::burst_len_t  sdram_wr_burst,
  output sdram_cmd_pkg::word_t       sdram_din,
  input  logic                       sdram_wr_ack,
  output logic                       sdram_rd_req,
  output sdram_cmd_pkg::burst_len_t  sdram_rd_burst,
  input  logic                       sdram_rd_ack,
  input  sdram_cmd_pkg::word_t       sdram_dout
);

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_e;

  seq_state_e                 state;
  logic                       owner_blk;  // stream block owns the port
  host_port_pkg::block_idx_t  cnt;

  logic                       grant;
  logic                       win_blk;
  sdram_cmd_pkg::burst_op_e   win_op;
  sdram_cmd_pkg::sdram_addr_t win_addr;
  sdram_cmd_pkg::burst_len_t  win_len;

  sdram_cmd_pkg::burst_len_t  cur_len;
  logic                       beat_ack;
  logic                       last_beat;

  // line_if first, and never while an ack is still out
  assign win_blk  = !line_if.req;
  assign grant    = (state == SEQ_IDLE) && !line_if.ack && !block_if.ack &&
                    (line_if.req || block_if.req);
  assign win_op   = win_blk ? block_if.op   : line_if.op;
  assign win_addr = win_blk ? block_if.addr : line_if.addr;
  assign win_len  = win_blk ? block_if.len  : line_if.len;

  assign beat_ack  = (sdram_wr_req && sdram_wr_ack) || (sdram_rd_req && sdram_rd_ack);
  assign last_beat = beat_ack && (cnt == host_port_pkg::block_idx_t'(cur_len - 1'b1));

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state        <= SEQ_IDLE;
      owner_blk    <= 1'b0;
      cnt          <= '0;
      sdram_wr_req <= 1'b0;
      sdram_rd_req <= 1'b0;
      line_if.ack  <= 1'b0;
      block_if.ack <= 1'b0;
    end else begin
      line_if.ack  <= 1'b0;
      block_if.ack <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (grant) begin
            state        <= SEQ_RUN;
            owner_blk    <= win_blk;
            cnt          <= '0;
            sdram_wr_req <= (win_op == sdram_cmd_pkg::BURST_WRITE);
            sdram_rd_req <= (win_op == sdram_cmd_pkg::BURST_READ);
          end
        end
        SEQ_RUN: begin
          if (last_beat) begin
            state        <= SEQ_IDLE;
            sdram_wr_req <= 1'b0;
            sdram_rd_req <= 1'b0;
            if (owner_blk) begin
              block_if.ack <= 1'b1;
            end else begin
              line_if.ack <= 1'b1;
            end
          end else if (beat_ack) begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // command payload latched once per burst
  always_ff @(posedge clk) begin
    if (grant) begin
      sdram_rw_addr <= win_addr;
      cur_len       <= win_len;
    end
  end

  assign sdram_wr_burst = cur_len;
  assign sdram_rd_burst = cur_len;

  assign busy = (state == SEQ_RUN);

  assign sdram_din = owner_blk ? block_if.wdata : line_if.wdata;

  assign line_if.beat    = cnt;
  assign block_if.beat   = cnt;
  assign line_if.rdata   = sdram_dout;
  assign block_if.rdata  = sdram_dout;
  assign line_if.rvalid  = sdram_rd_req && sdram_rd_ack && !owner_blk;
  assign block_if.rvalid = sdram_rd_req && sdram_rd_ack && owner_blk;

endmodule

`default_nettype wire

//--- logic/sdram_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_frontend_top (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_cmd_pkg::sdram_addr_t address,
  input  sdram_cmd_pkg::word_t       data_in,
  output sdram_cmd_pkg::word_t       data_out,
  input  logic                       read_req,
  output logic                       read_ack,
  input  logic                       write_req,
  output logic                       write_ack,
  input  logic                       write_latch_address,
  input  logic                       write_en,
  output logic                       busy,
  output sdram_cmd_pkg::sdram_addr_t sdram_rw_addr,
  output logic                       sdram_wr_req,
  output sdram_cmd_pkg::burst_len_t  sdram_wr_burst,
  output sdram_cmd_pkg::word_t       sdram_din,
  input  logic                       sdram_wr_ack,
  output logic                       sdram_rd_req,
  output sdram_cmd_pkg::burst_len_t  sdram_rd_burst,
  input  logic                       sdram_rd_ack,
  input  sdram_cmd_pkg::word_t       sdram_dout
);

  burst_req_if line_if ();   // read fills and single writes
  burst_req_if block_if ();  // stream block flushes

  host_port u_host_port (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .address   (address),
    .data_in   (data_in),
    .read_req  (read_req),
    .write_req (write_req),
    .write_en  (write_en),
    .data_out  (data_out),
    .read_ack  (read_ack),
    .write_ack (write_ack),
    .line_if   (line_if.requester)
  );

  stream_write_buffer u_stream_write_buffer (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .address             (address),
    .data_in             (data_in),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .block_if            (block_if.requester)
  );

  burst_sequencer u_burst_sequencer (
    .clk            (clk),
    .sys_rst_n      (sys_rst_n),
    .line_if        (line_if.sequencer),
    .block_if       (block_if.sequencer),
    .busy           (busy),
    .sdram_rw_addr  (sdram_rw_addr),
    .sdram_wr_req   (sdram_wr_req),
    .sdram_wr_burst (sdram_wr_burst),
    .sdram_din      (sdram_din),
    .sdram_wr_ack   (sdram_wr_ack),
    .sdram_rd_req   (sdram_rd_req),
    .sdram_rd_burst (sdram_rd_burst),
    .sdram_rd_ack   (sdram_rd_ack),
    .sdram_dout     (sdram_dout)
  );

endmodule

`default_nettype wire

//--- dv/sdram_frontend_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_frontend_properties (
  input logic                       clk,
  input logic                       sys_rst_n,
  input logic                       wr_req,
  input logic                       rd_req,
  input logic                       wr_ack,
  input logic                       rd_ack,
  input sdram_cmd_pkg::sdram_addr_t rw_addr,
  input sdram_cmd_pkg::burst_len_t  wr_len,
  input sdram_cmd_pkg::burst_len_t  rd_len,
  input logic                       blk_req,
  input logic                       blk_load   // stream write at block offset 15
);

  int unsigned fail_count = 0;

  // command fields held while the request stays up
  cmd_stable: assert property (@(posedge clk) disable iff (!sys_rst_n)
    (wr_req && $past(wr_req)) || (rd_req && $past(rd_req)) |->
      $stable(rw_addr) && $stable(wr_len) && $stable(rd_len))
    else begin
      $error("controller command changed while its request was up");
      fail_count++;
    end

  req_drop_after_beat: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $fell(wr_req) || $fell(rd_req) |-> $past(wr_ack || rd_ack))
    else begin
      $error("controller request dropped without a beat");
      fail_count++;
    end

  req_gap: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $fell(wr_req) || $fell(rd_req) |=> !wr_req && !rd_req)
    else begin
      $error("controller request rose right after one fell");
      fail_count++;
    end

  // no back-pressure on the stream, so a pending block must be gone
  blk_no_overrun: assert property (@(posedge clk) disable iff (!sys_rst_n)
    blk_load |-> !blk_req)
    else begin
      $error("stream block completed while the previous flush was pending");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- dv/tb_sdram_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_frontend;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_STREAM,
    OP_READ
  } tb_op_e;

  localparam int WAIT_LIMIT = 300;  // cycles for one handshake
  localparam int ROW_CYCLES = 400;

  logic                       clk;
  logic                       sys_rst_n;
  sdram_cmd_pkg::sdram_addr_t address;
  sdram_cmd_pkg::word_t       data_in;
  sdram_cmd_pkg::word_t       data_out;
  logic                       read_req;
  logic                       read_ack;
  logic                       write_req;
  logic                       write_ack;
  logic                       write_latch_address;
  logic                       write_en;
  logic                       busy;
  sdram_cmd_pkg::sdram_addr_t sdram_rw_addr;
  logic                       sdram_wr_req;
  sdram_cmd_pkg::burst_len_t  sdram_wr_burst;
  sdram_cmd_pkg::word_t       sdram_din;
  logic                       sdram_wr_ack;
  logic                       sdram_rd_req;
  sdram_cmd_pkg::burst_len_t  sdram_rd_burst;
  logic                       sdram_rd_ack;
  sdram_cmd_pkg::word_t       sdram_dout;

  string                      row_name [$];
  tb_op_e                     row_op   [$];
  sdram_cmd_pkg::sdram_addr_t row_addr [$];
  sdram_cmd_pkg::word_t       row_data [$];
  sdram_cmd_pkg::word_t       row_exp  [$];
  logic                       row_fill [$];  // read expected to miss

  sdram_cmd_pkg::word_t       ref_mem   [sdram_cmd_pkg::sdram_addr_t];
  sdram_cmd_pkg::word_t       model_mem [sdram_cmd_pkg::sdram_addr_t];
  host_port_pkg::line_tag_t   ref_tag;
  logic                       ref_valid = 1'b0;

  logic                       log_wr   [$];  // bursts seen by the controller model
  sdram_cmd_pkg::sdram_addr_t log_addr [$];
  sdram_cmd_pkg::burst_len_t  log_len  [$];
  int                         beats = 0;
  logic                       in_burst = 1'b0;
  int                         errors = 0;
  int                         n_rows = 0;

  sdram_frontend_top u_dut (.*);

  bind burst_sequencer sdram_frontend_properties u_seq_props (
    .clk     (clk),          .sys_rst_n (sys_rst_n),
    .wr_req  (sdram_wr_req), .rd_req    (sdram_rd_req),
    .wr_ack  (sdram_wr_ack), .rd_ack    (sdram_rd_ack),
    .rw_addr (sdram_rw_addr),
    .wr_len  (sdram_wr_burst), .rd_len  (sdram_rd_burst),
    .blk_req (1'b0),         .blk_load  (1'b0)
  );

  bind stream_write_buffer sdram_frontend_properties u_blk_props (
    .clk     (clk),          .sys_rst_n (sys_rst_n),
    .wr_req  (1'b0),         .rd_req    (1'b0),
    .wr_ack  (1'b0),         .rd_ack    (1'b0),
    .rw_addr ('0),
    .wr_len  ('0),           .rd_len    ('0),
    .blk_req (block_if.req), .blk_load  (write_en && last_slot)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // unwritten memory content
  function automatic sdram_cmd_pkg::word_t fill_word(sdram_cmd_pkg::sdram_addr_t a);
    return a[15:0] ^ {a[19:16], a[19:16], 8'h5a};
  endfunction

  function automatic sdram_cmd_pkg::word_t ref_word(sdram_cmd_pkg::sdram_addr_t a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return fill_word(a);
  endfunction

  function automatic sdram_cmd_pkg::word_t model_word(sdram_cmd_pkg::sdram_addr_t a);
    if (model_mem.exists(a)) return model_mem[a];
    return fill_word(a);
  endfunction

  function automatic void add_row(string name, tb_op_e op, sdram_cmd_pkg::sdram_addr_t addr,
                                  sdram_cmd_pkg::word_t data);
    logic fill;
    int   k;
    fill = 1'b0;
    case (op)
      OP_WRITE: begin
        ref_mem[addr] = data;
        ref_valid = 1'b0;
      end
      OP_STREAM: begin
        for (k = 0; k < 16; k++) begin
          ref_mem[sdram_cmd_pkg::sdram_addr_t'(addr + k)] = sdram_cmd_pkg::word_t'(data + k);
        end
        ref_valid = 1'b0;
      end
      default: begin
        fill = !(ref_valid && ref_tag == addr[19:2]);  // one-line cache
        ref_valid = 1'b1;
        ref_tag = addr[19:2];
      end
    endcase
    row_name.push_back(name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(op == OP_READ ? ref_word(addr) : data);
    row_fill.push_back(fill);
  endfunction

  function automatic void build_table();
    int k;
    add_row("wr_single", OP_WRITE, 20'h01235, 16'ha5c3);
    add_row("rd_after_wr", OP_READ, 20'h01235, '0);
    add_row("rd_line_hit", OP_READ, 20'h01236, '0);
    add_row("rd_line_end", OP_READ, 20'h01237, '0);
    add_row("wr_invalidate", OP_WRITE, 20'h01234, 16'h3c5a);
    add_row("rd_refill", OP_READ, 20'h01234, '0);
    add_row("stream_blk", OP_STREAM, 20'h04560, 16'h7100);
    for (k = 0; k < 16; k++) begin
      add_row($sformatf("rd_stream_%0d", k), OP_READ,
              sdram_cmd_pkg::sdram_addr_t'(20'h04560 + k), '0);
    end
  endfunction

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // controller model counts beats mid cycle
  always @(negedge clk) begin
    if (sdram_wr_req || sdram_rd_req) begin
      check_flag("busy during burst", 1'b1, busy);
      if (!in_burst) begin
        log_wr.push_back(sdram_wr_req);
        log_addr.push_back(sdram_rw_addr);
        log_len.push_back(sdram_wr_req ? sdram_wr_burst : sdram_rd_burst);
        in_burst = 1'b1;
      end
      if (sdram_wr_req && sdram_wr_ack) begin
        model_mem[sdram_cmd_pkg::sdram_addr_t'(sdram_rw_addr + beats)] = sdram_din;
        beats++;
      end else if (sdram_rd_req && sdram_rd_ack) begin
        beats++;
      end
    end else begin
      in_burst = 1'b0;
      beats = 0;
    end
  end

  initial begin
    void'($urandom(32'h8bb));
    forever begin
      @(posedge clk);
      #1;
      sdram_wr_ack = sdram_wr_req && (beats < sdram_wr_burst) && ($urandom % 4 != 0);
      sdram_rd_ack = sdram_rd_req && (beats < sdram_rd_burst) && ($urandom % 4 != 0);
      sdram_dout   = model_word(sdram_cmd_pkg::sdram_addr_t'(sdram_rw_addr + beats));
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(string name, sdram_cmd_pkg::word_t exp, sdram_cmd_pkg::word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, sdram_cmd_pkg::sdram_addr_t exp,
                            sdram_cmd_pkg::sdram_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_len(string name, sdram_cmd_pkg::burst_len_t exp,
                           sdram_cmd_pkg::burst_len_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_missing(string name, string what);
    $display("ERROR %s: no %s from the DUT within %0d cycles", name, what, WAIT_LIMIT);
    errors++;
  endtask

  task automatic expect_burst(string name, int n0, logic wr, sdram_cmd_pkg::sdram_addr_t addr,
                              sdram_cmd_pkg::burst_len_t len);
    if (log_len.size() != n0 + 1) begin
      $display("ERROR %s: expected one controller burst, the model saw %0d",
               name, log_len.size() - n0);
      errors++;
    end else begin
      check_flag({name, " op"}, wr, log_wr[n0]);
      check_addr({name, " addr"}, addr, log_addr[n0]);
      check_len({name, " len"}, len, log_len[n0]);
    end
  endtask

  task automatic run_row(int i);
    int n;
    int n0;
    int k;
    n = 0;
    n0 = log_len.size();
    address = row_addr[i];
    data_in = row_data[i];
    case (row_op[i])
      OP_WRITE: begin
        write_req = 1'b1;
        do begin
          step();
          n++;
        end while (!write_ack && n < WAIT_LIMIT);
        if (!write_ack) report_missing(row_name[i], "write_ack");
        write_req = 1'b0;
        step();
        expect_burst(row_name[i], n0, 1'b1, row_addr[i], sdram_cmd_pkg::LEN_SINGLE);
      end
      OP_STREAM: begin
        for (k = 0; k < 16; k++) begin
          write_latch_address = (k == 0);
          write_en = 1'b1;
          data_in = sdram_cmd_pkg::word_t'(row_data[i] + k);
          step();
        end
        write_latch_address = 1'b0;
        write_en = 1'b0;
        while ((log_len.size() == n0 || busy) && n < WAIT_LIMIT) begin
          step();
          n++;
        end
        if (log_len.size() == n0 || busy) report_missing(row_name[i], "block burst");
        expect_burst(row_name[i], n0, 1'b1, row_addr[i], sdram_cmd_pkg::LEN_BLOCK);
      end
      default: begin
        read_req = 1'b1;
        if (!row_fill[i]) begin
          step();  // hit answers one cycle after the edge
          check_flag({row_name[i], " hit ack"}, 1'b1, read_ack);
        end else begin
          do begin
            step();
            n++;
          end while (!read_ack && n < WAIT_LIMIT);
          if (!read_ack) report_missing(row_name[i], "read_ack");
        end
        check_word(row_name[i], row_exp[i], data_out);
        read_req = 1'b0;
        step();
        check_flag({row_name[i], " ack after drop"}, 1'b0, read_ack);
        check_word({row_name[i], " data after drop"}, '0, data_out);
        if (row_fill[i]) begin
          expect_burst(row_name[i], n0, 1'b0, {row_addr[i][19:2], 2'b00},
                       sdram_cmd_pkg::LEN_LINE);
        end else if (log_len.size() != n0) begin
          $display("ERROR %s: a cache hit sent a request to the controller", row_name[i]);
          errors++;
        end
      end
    endcase
  endtask

  initial begin
    int i;
    int prop_fails;
    sys_rst_n           = 1'b0;
    address             = '0;
    data_in             = '0;
    read_req            = 1'b0;
    write_req           = 1'b0;
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    sdram_wr_ack        = 1'b0;
    sdram_rd_ack        = 1'b0;
    sdram_dout          = '0;
    build_table();
    n_rows = row_name.size();
    repeat (8) @(posedge clk);
    #1;
    sys_rst_n = 1'b1;
    check_flag("reset read_ack", 1'b0, read_ack);
    check_flag("reset write_ack", 1'b0, write_ack);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset sdram_wr_req", 1'b0, sdram_wr_req);
    check_flag("reset sdram_rd_req", 1'b0, sdram_rd_req);
    check_word("reset data_out", '0, data_out);
    for (i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    repeat (4) step();
    prop_fails = u_dut.u_burst_sequencer.u_seq_props.fail_count +
                 u_dut.u_stream_write_buffer.u_blk_props.fail_count;
    $display("%0d rows run, %0d check errors, %0d assertion failures",
             n_rows, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    wait (n_rows > 0);
    repeat (n_rows * ROW_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", n_rows * ROW_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
logic/sdram_cmd_pkg.sv
logic/host_port_pkg.sv
logic/burst_req_if.sv
logic/host_port.sv
logic/stream_write_buffer.sv
logic/burst_sequencer.sv
logic/sdram_frontend_top.sv
dv/sdram_frontend_properties.sv
dv/tb_sdram_frontend.sv

//--- Bender.yml
package:
  name: sdram_frontend

dependencies: {}

sources:
  - logic/sdram_cmd_pkg.sv
  - logic/host_port_pkg.sv
  - logic/burst_req_if.sv
  - logic/host_port.sv
  - logic/stream_write_buffer.sv
  - logic/burst_sequencer.sv
  - logic/sdram_frontend_top.sv
  - target: test
    files:
      - dv/sdram_frontend_properties.sv
      - dv/tb_sdram_frontend.sv
